//--- hw/blob_pkg.sv
`default_nettype none

package blob_pkg;

	////////////////////
	// Pixel and coordinate types
	////////////////////

	typedef logic [7:0] channel_t;

	typedef struct packed {
		channel_t red;   // Bits 23:16
		channel_t green;
		channel_t blue;  // Bits 7:0
	} pixel_t;

	typedef logic [10:0] coord_t;

	// Frame geometry
	localparam coord_t IMAGE_W = 11'd640;
	localparam coord_t IMAGE_H = 11'd480;
	localparam coord_t COORD_NONE = 11'd2047;  // Never equals a real x or y

	// Consecutive hits needed, current pixel included
	localparam int RED_RUN = 6;
	localparam int BLUE_RUN = 5;
	localparam int ORANGE_RUN = 6;

	// Largest single step a box edge may take
	localparam coord_t GAP_LIMIT = 11'd5;

	////////////////////
	// Classification thresholds
	////////////////////

	localparam channel_t RED_MARGIN = 8'd30;      // Red lead over green and blue
	localparam channel_t BLUE_SLACK = 8'd20;      // Blue may trail green by less
	localparam channel_t ORANGE_HUE_LO = 8'd15;   // Half degrees
	localparam channel_t ORANGE_HUE_HI = 8'd30;
	localparam channel_t ORANGE_MIN_VAL = 8'd120;
	localparam channel_t ORANGE_MIN_SAT = 8'd110;

	// Flag and box colours
	localparam pixel_t COL_RED = 24'hff0000;
	localparam pixel_t COL_BLUE = 24'h0000ff;
	localparam pixel_t COL_ORANGE = 24'hde9a07;

	// Low nibble of blue in the start word of a video packet
	localparam logic [3:0] VIDEO_ID = 4'h0;

endpackage

`default_nettype wire

//--- hw/stream_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stream_reg (
	input  logic             clk,
	input  logic             reset_n,
	input  logic             valid_i,
	output logic             ready_o,
	input  blob_pkg::pixel_t pixel_i,
	input  logic             sop_i,
	input  logic             eop_i,
	output logic             valid_o,
	input  logic             ready_i,
	output blob_pkg::pixel_t pixel_o,
	output logic             sop_o,
	output logic             eop_o
);

	logic full;
	logic load;

	// Accept when empty or when the held word leaves this cycle
	assign ready_o = ~full | ready_i;
	assign load = valid_i & ready_o;
	assign valid_o = full;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			full <= 1'b0;
		end else if (load) begin
			full <= 1'b1;
		end else if (ready_i) begin
			full <= 1'b0;  // Drained with nothing behind it
		end
	end

	// Payload
	always_ff @(posedge clk) begin
		if (load) begin
			pixel_o <= pixel_i;
			sop_o <= sop_i;
			eop_o <= eop_i;
		end
	end

endmodule

`default_nettype wire

//--- hw/pixel_locator.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_locator (
	input  logic             clk,
	input  logic             reset_n,
	input  logic             valid_i,
	input  logic             ready_i,
	input  logic             sop_i,
	input  logic             eop_i,
	input  blob_pkg::pixel_t pixel_i,
	output logic             advance_o,
	output logic             frame_start_o,
	output logic             frame_end_o,
	output logic             video_o,
	output blob_pkg::coord_t x_o,
	output blob_pkg::coord_t y_o
);

	import blob_pkg::*;

	// One strobe per word moving from in_reg to out_reg
	assign advance_o = valid_i & ready_i;
	assign frame_start_o = advance_o & sop_i;
	assign frame_end_o = advance_o & eop_i & video_o;

	////////////////////
	// Position counters
	////////////////////

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			x_o <= '0;
			y_o <= '0;
			video_o <= 1'b0;
		end else if (advance_o) begin
			if (sop_i) begin
				x_o <= '0;
				y_o <= '0;
				video_o <= (pixel_i.blue[3:0] == VIDEO_ID);  // Packet type from descriptor
			end else if (x_o == IMAGE_W - 11'd1) begin
				x_o <= '0;  // End of line
				y_o <= y_o + 11'd1;
			end else begin
				x_o <= x_o + 11'd1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/colour_classifier.sv
`timescale 1ns/1ps
`default_nettype none

module colour_classifier (
	input  logic             clk,
	input  logic             reset_n,
	input  blob_pkg::pixel_t pixel_i,
	input  logic             advance_i,
	output logic             red_hit_o,
	output logic             blue_hit_o,
	output logic             orange_hit_o
);

	import blob_pkg::*;

	channel_t val;
	channel_t mn;
	channel_t delta;
	channel_t sat;
	channel_t hue;
	logic [15:0] sat_full;
	logic signed [15:0] hue_deg;
	logic red_test;
	logic blue_test;
	logic orange_test;
	logic [RED_RUN-2:0] red_hist;
	logic [BLUE_RUN-2:0] blue_hist;
	logic [ORANGE_RUN-2:0] orange_hist;

	////////////////////
	// HSV conversion
	////////////////////

	always_comb begin
		val = (pixel_i.red > pixel_i.green) ? pixel_i.red : pixel_i.green;
		if (pixel_i.blue > val)
			val = pixel_i.blue;
		mn = (pixel_i.red < pixel_i.green) ? pixel_i.red : pixel_i.green;
		if (pixel_i.blue < mn)
			mn = pixel_i.blue;
	end

	assign delta = val - mn;

	always_comb begin
		sat_full = '0;
		if (val != 8'd0)
			sat_full = ({8'd0, delta} * 16'd255) / {8'd0, val};
	end

	assign sat = sat_full[7:0];  // Never above 255

	// Six-sector hue in degrees, red sector may go negative
	always_comb begin
		logic signed [15:0] r_s;
		logic signed [15:0] g_s;
		logic signed [15:0] b_s;
		logic signed [15:0] d_s;
		r_s = signed'({8'd0, pixel_i.red});
		g_s = signed'({8'd0, pixel_i.green});
		b_s = signed'({8'd0, pixel_i.blue});
		d_s = signed'({8'd0, delta});
		hue_deg = '0;
		if (delta != 8'd0) begin
			if (val == pixel_i.red)
				hue_deg = (16'sd60 * (g_s - b_s)) / d_s;
			else if (val == pixel_i.green)
				hue_deg = 16'sd120 + (16'sd60 * (b_s - r_s)) / d_s;
			else
				hue_deg = 16'sd240 + (16'sd60 * (r_s - g_s)) / d_s;
			if (hue_deg < 0)
				hue_deg = hue_deg + 16'sd360;
		end
	end

	assign hue = hue_deg[8:1];  // Half degrees, 0 to 179

	////////////////////
	// Colour tests
	////////////////////

	assign orange_test = (hue >= ORANGE_HUE_LO) && (hue <= ORANGE_HUE_HI)
		&& (val > ORANGE_MIN_VAL) && (sat > ORANGE_MIN_SAT);

	assign red_test = ({1'b0, pixel_i.red} > {1'b0, pixel_i.green} + {1'b0, RED_MARGIN})
		&& ({1'b0, pixel_i.red} > {1'b0, pixel_i.blue} + {1'b0, RED_MARGIN})
		&& !orange_test;

	assign blue_test = ({1'b0, pixel_i.blue} + {1'b0, BLUE_SLACK} > {1'b0, pixel_i.green})
		&& (pixel_i.blue > pixel_i.red)
		&& !orange_test;

	// Run histories only move when a word really transfers
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			red_hist <= '0;
			blue_hist <= '0;
			orange_hist <= '0;
		end else if (advance_i) begin
			red_hist <= {red_hist[RED_RUN-3:0], red_test};
			blue_hist <= {blue_hist[BLUE_RUN-3:0], blue_test};
			orange_hist <= {orange_hist[ORANGE_RUN-3:0], orange_test};
		end
	end

	assign red_hit_o = red_test & (&red_hist);
	assign blue_hit_o = blue_test & (&blue_hist);
	assign orange_hit_o = orange_test & (&orange_hist);

endmodule

`default_nettype wire

//--- hw/box_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module box_tracker (
	input  logic             clk,
	input  logic             reset_n,
	input  logic             hit_i,
	input  logic             advance_i,
	input  logic             frame_start_i,
	input  logic             frame_end_i,
	input  blob_pkg::coord_t x_i,
	input  blob_pkg::coord_t y_i,
	output blob_pkg::coord_t left_o,
	output blob_pkg::coord_t right_o,
	output blob_pkg::coord_t top_o,
	output blob_pkg::coord_t bottom_o
);

	import blob_pkg::*;

	coord_t x_min;
	coord_t x_max;
	coord_t y_min;
	coord_t y_max;
	logic grow_left;
	logic grow_right;
	logic grow_top;

	// An edge jumps freely only while it still holds its start value
	assign grow_left = (x_i < x_min)
		&& ((x_min - x_i < GAP_LIMIT) || (x_min == IMAGE_W - 11'd1));
	assign grow_right = (x_i > x_max)
		&& ((x_i - x_max < GAP_LIMIT) || (x_max == 11'd0));
	assign grow_top = (y_i < y_min)
		&& ((y_min - y_i < GAP_LIMIT) || (y_min == IMAGE_H - 11'd1));

	////////////////////
	// Running bounds
	////////////////////

	always_ff @(posedge clk) begin
		if (!reset_n || frame_start_i) begin
			x_min <= IMAGE_W - 11'd1;
			x_max <= '0;
			y_min <= IMAGE_H - 11'd1;
			y_max <= '0;
		end else if (hit_i && advance_i) begin
			if (grow_left)
				x_min <= x_i;
			if (grow_right)
				x_max <= x_i;
			if (grow_top)
				y_min <= y_i;
			y_max <= y_min + (x_max - x_min);  // Square box from old width
		end
	end

	// Edges shown during the next frame
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			left_o <= COORD_NONE;
			right_o <= COORD_NONE;
			top_o <= COORD_NONE;
			bottom_o <= COORD_NONE;
		end else if (frame_end_i) begin
			left_o <= x_min;
			right_o <= x_max;
			top_o <= y_min;
			bottom_o <= y_max;
		end
	end

endmodule

`default_nettype wire

//--- hw/overlay_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module overlay_mixer (
	input  logic             clk,
	input  logic             reset_n,
	input  blob_pkg::pixel_t pixel_i,
	input  logic             sop_i,
	input  logic             video_i,
	input  logic             mode_i,
	input  blob_pkg::coord_t x_i,
	input  blob_pkg::coord_t y_i,
	input  logic             advance_i,
	input  logic             frame_start_i,
	input  logic             frame_end_i,
	input  logic             red_hit_i,
	input  logic             blue_hit_i,
	input  logic             orange_hit_i,
	output blob_pkg::pixel_t pixel_o
);

	import blob_pkg::*;

	coord_t red_l, red_r, red_t, red_b;
	coord_t blue_l, blue_r, blue_t, blue_b;
	coord_t orng_l, orng_r, orng_t, orng_b;
	logic red_active;
	logic blue_active;
	logic orange_active;
	channel_t grey;
	pixel_t painted;

	box_tracker red_box (
		.clk(clk), .reset_n(reset_n), .hit_i(red_hit_i), .advance_i(advance_i),
		.frame_start_i(frame_start_i), .frame_end_i(frame_end_i), .x_i(x_i), .y_i(y_i),
		.left_o(red_l), .right_o(red_r), .top_o(red_t), .bottom_o(red_b)
	);

	box_tracker blue_box (
		.clk(clk), .reset_n(reset_n), .hit_i(blue_hit_i), .advance_i(advance_i),
		.frame_start_i(frame_start_i), .frame_end_i(frame_end_i), .x_i(x_i), .y_i(y_i),
		.left_o(blue_l), .right_o(blue_r), .top_o(blue_t), .bottom_o(blue_b)
	);

	box_tracker orange_box (
		.clk(clk), .reset_n(reset_n), .hit_i(orange_hit_i), .advance_i(advance_i),
		.frame_start_i(frame_start_i), .frame_end_i(frame_end_i), .x_i(x_i), .y_i(y_i),
		.left_o(orng_l), .right_o(orng_r), .top_o(orng_t), .bottom_o(orng_b)
	);

	// Pixel lies on one of the four box lines
	assign red_active = (x_i == red_l) | (x_i == red_r) | (y_i == red_t) | (y_i == red_b);
	assign blue_active = (x_i == blue_l) | (x_i == blue_r) | (y_i == blue_t) | (y_i == blue_b);
	assign orange_active = (x_i == orng_l) | (x_i == orng_r) | (y_i == orng_t) | (y_i == orng_b);

	assign grey = {1'b0, pixel_i.green[7:1]} + {2'b0, pixel_i.red[7:2]}
		+ {2'b0, pixel_i.blue[7:2]};

	// Boxes over flags over grey
	always_comb begin
		if (red_active)
			painted = COL_RED;
		else if (blue_active)
			painted = COL_BLUE;
		else if (orange_active)
			painted = COL_ORANGE;
		else if (red_hit_i)
			painted = COL_RED;
		else if (blue_hit_i)
			painted = COL_BLUE;
		else if (orange_hit_i)
			painted = COL_ORANGE;
		else
			painted = {grey, grey, grey};
	end

	// Descriptor words and non-video packets go through untouched
	assign pixel_o = (mode_i && !sop_i && video_i) ? painted : pixel_i;

endmodule

`default_nettype wire

//--- hw/blob_top.sv
`timescale 1ns/1ps
`default_nettype none

module blob_top (
	input  logic             clk,
	input  logic             reset_n,
	input  blob_pkg::pixel_t sink_data_i,
	input  logic             sink_valid_i,
	input  logic             sink_sop_i,
	input  logic             sink_eop_i,
	output logic             sink_ready_o,
	output blob_pkg::pixel_t source_data_o,
	output logic             source_valid_o,
	output logic             source_sop_o,
	output logic             source_eop_o,
	input  logic             source_ready_i,
	input  logic             mode_i
);

	import blob_pkg::*;

	logic in_valid;
	logic out_ready;
	pixel_t in_pixel;
	logic in_sop;
	logic in_eop;
	logic advance;
	logic frame_start;
	logic frame_end;
	logic video;
	coord_t x;
	coord_t y;
	logic red_hit;
	logic blue_hit;
	logic orange_hit;
	pixel_t mix_pixel;

	////////////////////
	// Input slice
	////////////////////

	stream_reg in_reg (
		.clk(clk), .reset_n(reset_n),
		.valid_i(sink_valid_i), .ready_o(sink_ready_o),
		.pixel_i(sink_data_i), .sop_i(sink_sop_i), .eop_i(sink_eop_i),
		.valid_o(in_valid), .ready_i(out_ready),
		.pixel_o(in_pixel), .sop_o(in_sop), .eop_o(in_eop)
	);

	// Locator and classifier both look at the word held in in_reg
	pixel_locator locator (
		.clk(clk), .reset_n(reset_n),
		.valid_i(in_valid), .ready_i(out_ready),
		.sop_i(in_sop), .eop_i(in_eop), .pixel_i(in_pixel),
		.advance_o(advance), .frame_start_o(frame_start), .frame_end_o(frame_end),
		.video_o(video), .x_o(x), .y_o(y)
	);

	colour_classifier classifier (
		.clk(clk), .reset_n(reset_n), .pixel_i(in_pixel), .advance_i(advance),
		.red_hit_o(red_hit), .blue_hit_o(blue_hit), .orange_hit_o(orange_hit)
	);

	overlay_mixer mixer (
		.clk(clk), .reset_n(reset_n), .pixel_i(in_pixel), .sop_i(in_sop),
		.video_i(video), .mode_i(mode_i), .x_i(x), .y_i(y), .advance_i(advance),
		.frame_start_i(frame_start), .frame_end_i(frame_end),
		.red_hit_i(red_hit), .blue_hit_i(blue_hit), .orange_hit_i(orange_hit),
		.pixel_o(mix_pixel)
	);

	////////////////////
	// Output slice
	////////////////////

	stream_reg out_reg (
		.clk(clk), .reset_n(reset_n),
		.valid_i(in_valid), .ready_o(out_ready),
		.pixel_i(mix_pixel), .sop_i(in_sop), .eop_i(in_eop),
		.valid_o(source_valid_o), .ready_i(source_ready_i),
		.pixel_o(source_data_o), .sop_o(source_sop_o), .eop_o(source_eop_o)
	);

endmodule

`default_nettype wire

//--- bench/blob_tb.sv
`timescale 1ns/1ps
`default_nettype none

module blob_tb;

	import blob_pkg::*;

	localparam int FRAME_W = int'(IMAGE_W);
	localparam int FRAME_H = int'(IMAGE_H);
	localparam int GAP = int'(GAP_LIMIT);
	localparam int FRAMES = 6;  // Video frames plus the short packet
	localparam longint FRAME_WORDS = longint'(IMAGE_W) * longint'(IMAGE_H) + 1;
	localparam longint WATCHDOG_NS = 4 * FRAMES * FRAME_WORDS * 20;

	localparam int PAT_PLAIN = 0;
	localparam int PAT_RUNS = 1;
	localparam int PAT_PATCH = 2;
	localparam int PAT_RANDOM = 3;

	localparam pixel_t BACKGROUND = 24'h406040;  // Greys to 505050, no colour hit
	localparam pixel_t VIDEO_SOP = 24'h123450;   // Blue low nibble 0

	logic clk = 1'b0;
	logic reset_n;
	pixel_t sink_data_i;
	logic sink_valid_i;
	logic sink_sop_i;
	logic sink_eop_i;
	logic sink_ready_o;
	pixel_t source_data_o;
	logic source_valid_o;
	logic source_sop_o;
	logic source_eop_o;
	logic source_ready_i;
	logic mode_i;
	logic bp_enable;

	// Words to send and the words expected back
	pixel_t in_pix[$];
	logic in_sop[$];
	logic in_eop[$];
	pixel_t exp_pix[$];
	logic exp_sop[$];
	logic exp_eop[$];

	// Reference state, colour index 0 red, 1 blue, 2 orange
	int m_x;
	int m_y;
	logic m_video;
	int run_cnt[3];
	int box_l[3];
	int box_r[3];
	int box_t[3];
	int box_b[3];
	int show_l[3];
	int show_r[3];
	int show_t[3];
	int show_b[3];

	blob_top UUT (
		.clk(clk), .reset_n(reset_n),
		.sink_data_i(sink_data_i), .sink_valid_i(sink_valid_i),
		.sink_sop_i(sink_sop_i), .sink_eop_i(sink_eop_i), .sink_ready_o(sink_ready_o),
		.source_data_o(source_data_o), .source_valid_o(source_valid_o),
		.source_sop_o(source_sop_o), .source_eop_o(source_eop_o),
		.source_ready_i(source_ready_i), .mode_i(mode_i)
	);

	always #10 clk = ~clk;

	////////////////////
	// Compare tasks
	////////////////////

	task automatic check_pixel(input string name, input pixel_t got, input pixel_t want);
		if (got !== want) begin
			$display("ERROR %s: got %h, expected %h", name, got, want);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("ERROR %s: got %h, expected %h", name, got, want);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	////////////////////
	// Reference model
	////////////////////

	function automatic int run_len(input int c);
		if (c == 0)
			return RED_RUN;
		else if (c == 1)
			return BLUE_RUN;
		return ORANGE_RUN;
	endfunction

	function automatic pixel_t flag_colour(input int c);
		if (c == 0)
			return COL_RED;
		else if (c == 1)
			return COL_BLUE;
		return COL_ORANGE;
	endfunction

	// Bit 0 red, bit 1 blue, bit 2 orange
	function automatic logic [2:0] colour_tests(input pixel_t p);
		int r;
		int g;
		int b;
		int mx;
		int mn;
		int d;
		int sat;
		int hue;
		logic [2:0] t;
		r = int'(p.red);
		g = int'(p.green);
		b = int'(p.blue);
		mx = r;
		if (g > mx)
			mx = g;
		if (b > mx)
			mx = b;
		mn = r;
		if (g < mn)
			mn = g;
		if (b < mn)
			mn = b;
		d = mx - mn;
		sat = (mx == 0) ? 0 : d * 255 / mx;
		hue = 0;
		if (d != 0) begin
			if (mx == r)
				hue = 60 * (g - b) / d;
			else if (mx == g)
				hue = 120 + 60 * (b - r) / d;
			else
				hue = 240 + 60 * (r - g) / d;
			if (hue < 0)
				hue = hue + 360;
			hue = hue / 2;  // Half degrees
		end
		t[2] = (hue >= int'(ORANGE_HUE_LO)) && (hue <= int'(ORANGE_HUE_HI))
			&& (mx > int'(ORANGE_MIN_VAL)) && (sat > int'(ORANGE_MIN_SAT));
		t[0] = (r > g + int'(RED_MARGIN)) && (r > b + int'(RED_MARGIN)) && !t[2];
		t[1] = (b + int'(BLUE_SLACK) > g) && (b > r) && !t[2];
		return t;
	endfunction

	task automatic reset_model;
		int c;
		m_x = 0;
		m_y = 0;
		m_video = 1'b0;
		for (c = 0; c < 3; c++) begin
			run_cnt[c] = 0;
			box_l[c] = FRAME_W - 1;
			box_r[c] = 0;
			box_t[c] = FRAME_H - 1;
			box_b[c] = 0;
			show_l[c] = int'(COORD_NONE);
			show_r[c] = int'(COORD_NONE);
			show_t[c] = int'(COORD_NONE);
			show_b[c] = int'(COORD_NONE);
		end
	endtask

	// One word through the model, in transfer order
	task automatic predict_word(input pixel_t p, input logic sop, input logic eop,
		input logic mode, output pixel_t out);
		logic [2:0] tests;
		logic [2:0] hits;
		logic [2:0] active;
		pixel_t painted;
		int gv;
		int c;
		int nl;
		int nr;
		int nt;
		tests = colour_tests(p);
		for (c = 0; c < 3; c++) begin
			hits[c] = tests[c] && (run_cnt[c] >= run_len(c) - 1);
			active[c] = (m_x == show_l[c]) || (m_x == show_r[c])
				|| (m_y == show_t[c]) || (m_y == show_b[c]);
		end
		gv = int'(p.green) / 2 + int'(p.red) / 4 + int'(p.blue) / 4;
		painted = {8'(gv), 8'(gv), 8'(gv)};
		for (c = 2; c >= 0; c--)
			if (hits[c])
				painted = flag_colour(c);  // Red ends up on top
		for (c = 2; c >= 0; c--)
			if (active[c])
				painted = flag_colour(c);
		out = (mode && !sop && m_video) ? painted : p;

		if (eop && m_video) begin
			for (c = 0; c < 3; c++) begin
				show_l[c] = box_l[c];
				show_r[c] = box_r[c];
				show_t[c] = box_t[c];
				show_b[c] = box_b[c];
			end
		end
		for (c = 0; c < 3; c++) begin
			run_cnt[c] = tests[c] ? run_cnt[c] + 1 : 0;
			if (sop) begin
				box_l[c] = FRAME_W - 1;
				box_r[c] = 0;
				box_t[c] = FRAME_H - 1;
				box_b[c] = 0;
			end else if (hits[c]) begin
				nl = box_l[c];
				nr = box_r[c];
				nt = box_t[c];
				if (m_x < box_l[c] && (box_l[c] - m_x < GAP || box_l[c] == FRAME_W - 1))
					nl = m_x;
				if (m_x > box_r[c] && (m_x - box_r[c] < GAP || box_r[c] == 0))
					nr = m_x;
				if (m_y < box_t[c] && (box_t[c] - m_y < GAP || box_t[c] == FRAME_H - 1))
					nt = m_y;
				box_b[c] = (box_t[c] + box_r[c] - box_l[c]) & 2047;  // 11-bit wrap
				box_l[c] = nl;
				box_r[c] = nr;
				box_t[c] = nt;
			end
		end
		if (sop) begin
			m_x = 0;
			m_y = 0;
			m_video = (p.blue[3:0] == VIDEO_ID);
		end else if (m_x == FRAME_W - 1) begin
			m_x = 0;
			m_y = m_y + 1;
		end else begin
			m_x = m_x + 1;
		end
	endtask

	////////////////////
	// Stimulus
	////////////////////

	task automatic add_word(input pixel_t p, input logic sop, input logic eop,
		input logic mode);
		pixel_t out;
		predict_word(p, sop, eop, mode, out);
		in_pix.push_back(p);
		in_sop.push_back(sop);
		in_eop.push_back(eop);
		exp_pix.push_back(out);
		exp_sop.push_back(sop);
		exp_eop.push_back(eop);
	endtask

	function automatic pixel_t frame_pixel(input int pattern, input int x, input int y);
		logic [31:0] rnd;
		pixel_t p;
		p = BACKGROUND;
		case (pattern)
			PAT_RUNS: begin
				// Row 10 long runs, row 20 runs one short of qualifying
				if (y == 10 && x >= 50 && x < 70)
					p = 24'hff0000;
				else if (y == 10 && x >= 100 && x < 120)
					p = 24'h0000ff;
				else if (y == 10 && x >= 150 && x < 170)
					p = 24'hde9a07;
				else if (y == 20 && x >= 40 && x < 45)
					p = 24'hff0000;
				else if (y == 20 && x >= 80 && x < 84)
					p = 24'h0000ff;
				else if (y == 20 && x >= 120 && x < 125)
					p = 24'hde9a07;
			end
			PAT_PATCH: begin
				if (x >= 200 && x < 240 && y >= 100 && y < 140)
					p = 24'hff0000;
				else if (x >= 400 && x < 440 && y >= 300 && y < 340)
					p = 24'hde9a07;
			end
			PAT_RANDOM: begin
				rnd = $urandom();
				p = rnd[23:0];
			end
			default: ;
		endcase
		return p;
	endfunction

	task automatic add_video_frame(input int pattern, input logic mode);
		int x;
		int y;
		add_word(VIDEO_SOP, 1'b1, 1'b0, mode);
		for (y = 0; y < FRAME_H; y++)
			for (x = 0; x < FRAME_W; x++)
				add_word(frame_pixel(pattern, x, y), 1'b0,
					(x == FRAME_W - 1) && (y == FRAME_H - 1), mode);
	endtask

	task automatic send_words;
		logic accepted;
		@(negedge clk);
		while (in_pix.size() != 0) begin
			sink_data_i = in_pix.pop_front();
			sink_sop_i = in_sop.pop_front();
			sink_eop_i = in_eop.pop_front();
			sink_valid_i = 1'b1;
			accepted = 1'b0;
			while (!accepted) begin
				#1;
				accepted = sink_ready_o;  // Transfers on the coming rising edge
				if (!bp_enable)
					check_flag("sink_ready_o", sink_ready_o, 1'b1);  // Free output never stalls
				@(negedge clk);
			end
		end
		sink_valid_i = 1'b0;
		sink_sop_i = 1'b0;
		sink_eop_i = 1'b0;
	endtask

	task automatic run_packet(input logic mode, input logic backpressure);
		@(negedge clk);
		mode_i = mode;
		bp_enable = backpressure;
		send_words();
		while (exp_pix.size() != 0)
			@(negedge clk);
		bp_enable = 1'b0;
	endtask

	////////////////////
	// Directed tests
	////////////////////

	task automatic verify_reset;
		int i;
		reset_model();
		for (i = 0; i < 10; i++) begin
			@(negedge clk);
			check_flag("source_valid_o", source_valid_o, 1'b0);
		end
		reset_n = 1'b1;
		for (i = 0; i < 4; i++) begin
			@(negedge clk);
			check_flag("source_valid_o", source_valid_o, 1'b0);
		end
	endtask

	// First video frame, no box edges yet
	task automatic qualify_runs;
		add_video_frame(PAT_RUNS, 1'b1);
		run_packet(1'b1, 1'b0);
	endtask

	task automatic stream_random_frame;
		add_video_frame(PAT_RANDOM, 1'b0);
		run_packet(1'b0, 1'b1);
	endtask

	task automatic pass_non_video;
		int i;
		logic [31:0] rnd;
		add_word(24'habc0d3, 1'b1, 1'b0, 1'b1);  // Packet type 3
		for (i = 0; i < 32; i++) begin
			rnd = $urandom();
			add_word(rnd[23:0], 1'b0, i == 31, 1'b1);
		end
		run_packet(1'b1, 1'b1);
	endtask

	task automatic track_boxes;
		add_video_frame(PAT_PATCH, 1'b1);
		run_packet(1'b1, 1'b0);
		add_video_frame(PAT_PLAIN, 1'b1);  // Shows the patch boxes
		run_packet(1'b1, 1'b0);
		add_video_frame(PAT_PLAIN, 1'b1);  // Shows edges of empty bounds
		run_packet(1'b1, 1'b0);
	endtask

	////////////////////
	// Processes
	////////////////////

	initial begin : drive_source_ready
		logic [31:0] rnd;
		source_ready_i = 1'b1;
		forever begin
			@(negedge clk);
			rnd = $urandom();
			source_ready_i = bp_enable ? rnd[0] : 1'b1;
		end
	end

	initial begin : collect_output
		pixel_t want_pix;
		logic want_sop;
		logic want_eop;
		forever begin
			@(negedge clk);
			#1;
			if (reset_n && source_valid_o && source_ready_i) begin
				if (exp_pix.size() == 0) begin
					$display("An output word appeared when none was expected");
					$display("SIMULATION FAILED");
					$fatal(1);
				end
				want_pix = exp_pix.pop_front();
				want_sop = exp_sop.pop_front();
				want_eop = exp_eop.pop_front();
				check_pixel("source_data_o", source_data_o, want_pix);
				check_flag("source_sop_o", source_sop_o, want_sop);
				check_flag("source_eop_o", source_eop_o, want_eop);
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Timeout, the output stream did not complete in time");
		$display("SIMULATION FAILED");
		$fatal(1);
	end

	initial begin
		void'($urandom(77));
		reset_n = 1'b0;
		sink_data_i = '0;
		sink_valid_i = 1'b0;
		sink_sop_i = 1'b0;
		sink_eop_i = 1'b0;
		mode_i = 1'b0;
		bp_enable = 1'b0;
		verify_reset();
		qualify_runs();
		stream_random_frame();
		pass_non_video();
		track_boxes();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
hw/blob_pkg.sv
hw/stream_reg.sv
hw/pixel_locator.sv
hw/colour_classifier.sv
hw/box_tracker.sv
hw/overlay_mixer.sv
hw/blob_top.sv
bench/blob_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing -j 0
TOP = blob_tb
FILELIST = compile.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
